//--- hdl/tcb_pkg.sv
/*
 * Shared definitions for the TCB subsystem.
 * Holds the bus widths, the response delays, the request, response and
 * metadata structs, and the helpers that decode a select word into byte lanes.
 * Every RTL module imports this package.
 */

package tcb_pkg;

    //////////////////////////////
    // bus geometry and delays
    //////////////////////////////

    // data width and byte lane count
    localparam int unsigned TCB_DAT = 32;
    localparam int unsigned TCB_BYT = TCB_DAT / 8;
    // byte address width
    localparam int unsigned TCB_ADR = 12;

    // sram size in bytes, anything at or above is out of range
    localparam int unsigned MEM_BYTES = 1024;
    localparam int unsigned MEM_ADR = $clog2(MEM_BYTES);

    // sram read delay, then one more stage in the response slice
    localparam int unsigned DLY_MEM = 1;
    localparam int unsigned DLY_SUB = DLY_MEM + 1;

    //////////////////////////////
    // transfer types
    //////////////////////////////

    // one select word with two readings
    // log mode uses only the low two bits as a size code
    typedef union packed {
        struct packed {
            logic [TCB_BYT-3:0] pad;
            logic [1:0]         siz;
        } log;
        logic [TCB_BYT-1:0] byt;
    } tcb_sel_u;

    // request as driven by the manager
    typedef struct packed {
        logic               wen;
        logic               mod;
        tcb_sel_u           sel;
        logic [TCB_ADR-1:0] adr;
        logic [TCB_DAT-1:0] wdt;
    } tcb_req_t;

    // response from the subordinate and from the slice
    typedef struct packed {
        logic [TCB_DAT-1:0] rdt;
        logic               err;
    } tcb_rsp_t;

    // request fields carried down the delay stages
    typedef struct packed {
        logic     wen;
        logic     mod;
        tcb_sel_u sel;
    } tcb_meta_t;

    //////////////////////////////
    // lane decode helpers
    //////////////////////////////

    // lanes enabled by a transfer
    // log mode enables the low 2**siz lanes, byte mode passes the mask through
    function automatic logic [TCB_BYT-1:0] lane_mask(input logic mod, input tcb_sel_u sel);
        logic [TCB_BYT-1:0] msk;
        for (int unsigned i = 0; i < TCB_BYT; i++) begin
            if (mod) begin
                msk[i] = sel.byt[i];
            end else begin
                msk[i] = (i < (1 << sel.log.siz));
            end
        end
        return msk;
    endfunction

    // log mode address must be a multiple of the transfer size
    // byte mode has no alignment rule
    function automatic logic sel_misaligned(input logic mod, input tcb_sel_u sel,
                                            input logic [TCB_ADR-1:0] adr);
        logic [TCB_ADR-1:0] low;
        low = (TCB_ADR'(1) << sel.log.siz) - TCB_ADR'(1);
        return ~mod & (|(adr & low));
    endfunction

endpackage

//--- hdl/tcb_delay_ctrl.sv
/*
 * Delay control for the response path.
 * Tracks every accepted transfer through a shift register of valid flags
 * and keeps the request metadata up to the capture stage. Stage DLY_MEM
 * tells the response slice to capture, stage DLY_SUB marks the response
 * valid towards the manager.
 */

module tcb_delay_ctrl (
    input  logic              man,
    input  logic              arst_n,
    input  logic              acc,
    input  tcb_pkg::tcb_meta_t req_meta,
    output logic              cap_en,
    output tcb_pkg::tcb_meta_t cap_meta,
    output logic              rsp_vld
);

    import tcb_pkg::*;

    // one flag per stage, stage 1 is set on the accept edge
    logic [DLY_SUB:1] trn;

    // metadata for the stages up to the capture point
    tcb_meta_t meta [1:DLY_MEM];

    //////////////////////////////
    // transfer flags
    //////////////////////////////

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            trn <= '0;
        end else begin
            // shift towards the manager, new transfer enters at stage 1
            trn <= {trn[DLY_SUB-1:1], acc};
        end
    end

    //////////////////////////////
    // metadata stages
    //////////////////////////////

    always_ff @(posedge man) begin
        // first stage follows the bus only on accept
        if (acc) begin
            meta[1] <= req_meta;
        end
        // later stages move along with their flag
        for (int unsigned k = 2; k <= DLY_MEM; k++) begin
            if (trn[k-1]) begin
                meta[k] <= meta[k-1];
            end
        end
    end

    // capture command lines up with the sram read data
    assign cap_en   = trn[DLY_MEM];
    assign cap_meta = meta[DLY_MEM];

    // response valid lines up with the slice output
    assign rsp_vld = trn[DLY_SUB];

    // new metadata always arrives together with its capture command
    assert property (@(posedge man) disable iff (!arst_n)
        !$stable(cap_meta) |-> cap_en);

endmodule

//--- hdl/tcb_register_response.sv
/*
 * Register slice on the response path.
 * Adds one cycle after the sram. On a capture command it always takes the
 * error flag, and for reads only the byte lanes that the transfer selected.
 * Lanes that were not selected hold what an earlier read left there.
 */

module tcb_register_response (
    input  logic              man,
    input  logic              arst_n,
    input  logic              cap_en,
    input  tcb_pkg::tcb_meta_t cap_meta,
    input  tcb_pkg::tcb_rsp_t  sub_rsp,
    output tcb_pkg::tcb_rsp_t  rsp
);

    import tcb_pkg::*;

    // lanes selected by the transfer being captured
    logic [TCB_BYT-1:0] cap_lane;

    assign cap_lane = lane_mask(cap_meta.mod, cap_meta.sel);

    //////////////////////////////
    // response register
    //////////////////////////////

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else if (cap_en) begin
            // writes return no data, rdt stays as it was
            if (!cap_meta.wen) begin
                for (int unsigned i = 0; i < TCB_BYT; i++) begin
                    if (cap_lane[i]) begin
                        rsp.rdt[i*8+:8] <= sub_rsp.rdt[i*8+:8];
                    end
                end
            end
            // error flag is taken for reads and writes alike
            rsp.err <= sub_rsp.err;
        end
    end

    // read data only moves on the edge that the delay control picked
    assert property (@(posedge man) disable iff (!arst_n)
        !$stable(rsp.rdt) |-> $past(cap_en));

endmodule

//--- hdl/tcb_sram_sub.sv
/*
 * SRAM subordinate on the TCB.
 * Byte wide memory of MEM_BYTES entries. Enabled lanes map to successive
 * addresses from the request address. Read data and error come one cycle
 * after accept. An out of range or misaligned request reports an error and
 * leaves memory alone. Every accepted write holds rdy low for one cycle.
 */

module tcb_sram_sub (
    input  logic             man,
    input  logic             arst_n,
    input  logic             vld,
    input  tcb_pkg::tcb_req_t req,
    output logic             rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    import tcb_pkg::*;

    // storage, one byte per entry
    logic [7:0] mem [MEM_BYTES];

    // handshake
    logic acc;
    logic stall;

    // request decode
    logic [TCB_BYT-1:0] lane;
    logic               err_rng;
    logic               err_aln;
    logic               err;
    logic [MEM_ADR-1:0] idx [TCB_BYT];

    //////////////////////////////
    // handshake and commit stall
    //////////////////////////////

    assign acc = vld & rdy;
    assign rdy = ~stall;

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            stall <= 1'b0;
        end else begin
            // one idle cycle while a write commits
            stall <= acc & req.wen;
        end
    end

    //////////////////////////////
    // request decode
    //////////////////////////////

    always_comb begin
        lane    = lane_mask(req.mod, req.sel);
        err_rng = (req.adr >= TCB_ADR'(MEM_BYTES));
        err_aln = sel_misaligned(req.mod, req.sel, req.adr);
        err     = err_rng | err_aln;
        // lane i sits at adr+i, wraps inside the memory
        for (int unsigned i = 0; i < TCB_BYT; i++) begin
            idx[i] = req.adr[MEM_ADR-1:0] + MEM_ADR'(i);
        end
    end

    //////////////////////////////
    // memory access
    //////////////////////////////

    always_ff @(posedge man) begin
        if (acc) begin
            for (int unsigned i = 0; i < TCB_BYT; i++) begin
                if (req.wen) begin
                    // write only enabled lanes of a clean request
                    if (lane[i] && !err) begin
                        mem[idx[i]] <= req.wdt[i*8+:8];
                    end
                end else begin
                    // unselected lanes and failed reads return zero
                    rsp.rdt[i*8+:8] <= (lane[i] && !err) ? mem[idx[i]] : 8'h00;
                end
            end
            rsp.err <= err;
        end
    end

    // a request held off by the stall stays on the bus until accepted
    assert property (@(posedge man) disable iff (!arst_n)
        vld && !rdy |=> vld && $stable(req));

endmodule

//--- hdl/tcb_subsystem_top.sv
/*
 * Top level of the TCB subsystem.
 * The manager port goes straight to the sram, whose raw response passes
 * through the register slice. The delay control follows each accepted
 * transfer and marks the response valid two stages later.
 */

module tcb_subsystem_top (
    input  logic             man,
    input  logic             arst_n,
    input  logic             man_vld,
    input  tcb_pkg::tcb_req_t man_req,
    output logic             man_rdy,
    output tcb_pkg::tcb_rsp_t man_rsp,
    output logic             man_rsp_vld
);

    import tcb_pkg::*;

    // accept pulse and the request fields the slice needs later
    logic      acc;
    tcb_meta_t req_meta;

    // capture command from control to slice
    logic      cap_en;
    tcb_meta_t cap_meta;

    // raw sram response
    tcb_rsp_t  sub_rsp;

    assign acc          = man_vld & man_rdy;
    assign req_meta.wen = man_req.wen;
    assign req_meta.mod = man_req.mod;
    assign req_meta.sel = man_req.sel;

    tcb_delay_ctrl u_ctrl (
        .man      (man),
        .arst_n   (arst_n),
        .acc      (acc),
        .req_meta (req_meta),
        .cap_en   (cap_en),
        .cap_meta (cap_meta),
        .rsp_vld  (man_rsp_vld)
    );

    tcb_sram_sub u_sram (
        .man    (man),
        .arst_n (arst_n),
        .vld    (man_vld),
        .req    (man_req),
        .rdy    (man_rdy),
        .rsp    (sub_rsp)
    );

    tcb_register_response u_slice (
        .man      (man),
        .arst_n   (arst_n),
        .cap_en   (cap_en),
        .cap_meta (cap_meta),
        .sub_rsp  (sub_rsp),
        .rsp      (man_rsp)
    );

endmodule

//--- bench/tcb_tb_vectors.svh
/*
 * Stimulus table for the TCB subsystem testbench.
 * Included inside the testbench module body. Each row is one transfer,
 * applied back to back in table order.
 */

`ifndef TCB_TB_VECTORS_SVH
`define TCB_TB_VECTORS_SVH

// columns: name (12 chars), wen, mod, sel, adr, wdt, rnd, chk, rdt, err
// rnd replaces wdt with a random word
// chk marks rows whose expected rdt and err below are fixed
typedef struct packed {
    logic [95:0] name;
    logic        wen;
    logic        mod;
    logic [3:0]  sel;
    logic [11:0] adr;
    logic [31:0] wdt;
    logic        rnd;
    logic        chk;
    logic [31:0] rdt;
    logic        err;
} vec_t;

localparam int ROWS = 23;

vec_t vec [ROWS] = '{
    // word write, then read back
    '{"wr_word     ", 1'b1, 1'b0, 4'h2, 12'h010, 32'hA1B2C3D4, 1'b0, 1'b1, 32'h00000000, 1'b0},
    '{"rd_word     ", 1'b0, 1'b0, 4'h2, 12'h010, 32'h00000000, 1'b0, 1'b1, 32'hA1B2C3D4, 1'b0},
    // byte and half reads keep the upper lanes
    '{"wr_word2    ", 1'b1, 1'b0, 4'h2, 12'h020, 32'h11223344, 1'b0, 1'b1, 32'hA1B2C3D4, 1'b0},
    '{"rd_byte     ", 1'b0, 1'b0, 4'h0, 12'h020, 32'h00000000, 1'b0, 1'b1, 32'hA1B2C344, 1'b0},
    '{"rd_half     ", 1'b0, 1'b0, 4'h1, 12'h022, 32'h00000000, 1'b0, 1'b1, 32'hA1B21122, 1'b0},
    '{"rd_word2    ", 1'b0, 1'b0, 4'h2, 12'h020, 32'h00000000, 1'b0, 1'b1, 32'h11223344, 1'b0},
    // byte enable mode, lanes 1 and 3 only
    '{"wr_be_13    ", 1'b1, 1'b1, 4'hA, 12'h010, 32'h55667788, 1'b0, 1'b1, 32'h11223344, 1'b0},
    '{"rd_after_be ", 1'b0, 1'b0, 4'h2, 12'h010, 32'h00000000, 1'b0, 1'b1, 32'h55B277D4, 1'b0},
    '{"rd_be_sparse", 1'b0, 1'b1, 4'h5, 12'h020, 32'h00000000, 1'b0, 1'b1, 32'h55227744, 1'b0},
    '{"wr_be_0     ", 1'b1, 1'b1, 4'h1, 12'h031, 32'h000000EE, 1'b0, 1'b1, 32'h55227744, 1'b0},
    '{"rd_be_1     ", 1'b0, 1'b1, 4'h2, 12'h030, 32'h00000000, 1'b0, 1'b1, 32'h5522EE44, 1'b0},
    // range and alignment errors, 0x410 would wrap onto 0x010
    '{"wr_range    ", 1'b1, 1'b0, 4'h2, 12'h410, 32'hDEADBEEF, 1'b0, 1'b1, 32'h5522EE44, 1'b1},
    '{"wr_misalgn  ", 1'b1, 1'b0, 4'h1, 12'h011, 32'h0000CAFE, 1'b0, 1'b1, 32'h5522EE44, 1'b1},
    '{"rd_range    ", 1'b0, 1'b0, 4'h2, 12'h7FC, 32'h00000000, 1'b0, 1'b1, 32'h00000000, 1'b1},
    '{"rd_misalgn  ", 1'b0, 1'b0, 4'h2, 12'h012, 32'h00000000, 1'b0, 1'b1, 32'h00000000, 1'b1},
    '{"rd_check    ", 1'b0, 1'b0, 4'h2, 12'h010, 32'h00000000, 1'b0, 1'b1, 32'h55B277D4, 1'b0},
    // random words, then a run of back to back reads
    '{"wr_rnd0     ", 1'b1, 1'b0, 4'h2, 12'h100, 32'h00000000, 1'b1, 1'b0, 32'h00000000, 1'b0},
    '{"wr_rnd1     ", 1'b1, 1'b0, 4'h2, 12'h104, 32'h00000000, 1'b1, 1'b0, 32'h00000000, 1'b0},
    '{"rd_rnd0     ", 1'b0, 1'b0, 4'h2, 12'h100, 32'h00000000, 1'b0, 1'b0, 32'h00000000, 1'b0},
    '{"rd_rnd1     ", 1'b0, 1'b0, 4'h2, 12'h104, 32'h00000000, 1'b0, 1'b0, 32'h00000000, 1'b0},
    '{"rd_b2b_a    ", 1'b0, 1'b0, 4'h2, 12'h020, 32'h00000000, 1'b0, 1'b1, 32'h11223344, 1'b0},
    '{"rd_b2b_b    ", 1'b0, 1'b0, 4'h2, 12'h010, 32'h00000000, 1'b0, 1'b1, 32'h55B277D4, 1'b0},
    '{"rd_half_hi  ", 1'b0, 1'b0, 4'h1, 12'h012, 32'h00000000, 1'b0, 1'b1, 32'h55B255B2, 1'b0}
};

`endif

//--- bench/tcb_tb.sv
/*
 * Testbench for the TCB subsystem top level.
 * Applies the stimulus table back to back, predicts every response with a
 * shadow memory and a shadow slice register, and checks response data,
 * error flag, response timing and the write commit stall.
 */

module tcb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tcb_pkg::*;

    `include "tcb_tb_vectors.svh"

    // each row takes at most three cycles
    localparam int CYC_LIMIT = 4 * ROWS + 20;

    // expected response of one accepted transfer
    typedef struct packed {
        logic [95:0] name;
        int          acc_cyc;
        logic [31:0] rdt;
        logic        err;
        logic        chk;
        logic [31:0] tab_rdt;
        logic        tab_err;
    } pend_t;

    logic      man;
    logic      arst_n;
    logic      man_vld;
    tcb_req_t  man_req;
    logic      man_rdy;
    tcb_rsp_t  man_rsp;
    logic      man_rsp_vld;

    int        cyc = 0;
    int        checks = 0;
    int        errors = 0;
    int        nrsp = 0;
    pend_t     pend_q [$];

    // reference state
    logic [7:0]  shadow_mem [MEM_BYTES];
    logic [31:0] shadow_rdt = '0;

    tcb_subsystem_top dut (
        .man         (man),
        .arst_n      (arst_n),
        .man_vld     (man_vld),
        .man_req     (man_req),
        .man_rdy     (man_rdy),
        .man_rsp     (man_rsp),
        .man_rsp_vld (man_rsp_vld)
    );

    //////////////////////////////
    // clock and cycle limit
    //////////////////////////////

    initial begin
        man = 1'b0;
        forever #10 man = ~man;
    end

    always @(posedge man) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("timeout after %0d cycles, %0d responses still missing",
                     cyc, pend_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // log mode size 0/1/2 covers 1/2/4 low lanes
    function automatic logic [3:0] enabled_lanes(input logic mod, input logic [3:0] sel);
        if (mod) begin
            return sel;
        end
        case (sel[1:0])
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic is_misaligned(input logic mod, input logic [3:0] sel,
                                           input logic [11:0] adr);
        if (mod) begin
            return 1'b0;
        end
        case (sel[1:0])
            2'd1:    return adr[0];
            2'd2:    return |adr[1:0];
            default: return 1'b0;
        endcase
    endfunction

    // update shadow state on accept and queue the expected response
    task automatic predict_response(input tcb_req_t req, input vec_t v, input int acc_cyc);
        logic [3:0] lanes;
        logic       err;
        logic [9:0] a;
        pend_t      p;
        lanes = enabled_lanes(req.mod, req.sel);
        err   = (32'(req.adr) >= MEM_BYTES) || is_misaligned(req.mod, req.sel, req.adr);
        for (int i = 0; i < 4; i++) begin
            a = 10'(32'(req.adr) + i);
            if (lanes[i] && req.wen && !err) begin
                shadow_mem[a] = req.wdt[i*8 +: 8];
            end
            // a failed read captures zero in its lanes
            if (lanes[i] && !req.wen) begin
                shadow_rdt[i*8 +: 8] = err ? 8'h00 : shadow_mem[a];
            end
        end
        p.name    = v.name;
        p.acc_cyc = acc_cyc;
        p.rdt     = shadow_rdt;
        p.err     = err;
        p.chk     = v.chk;
        p.tab_rdt = v.rdt;
        p.tab_err = v.err;
        pend_q.push_back(p);
    endtask

    task automatic compare(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    //////////////////////////////
    // response monitor
    //////////////////////////////

    initial begin : monitor
        pend_t p;
        string nm;
        forever begin
            @(negedge man);
            if (arst_n && man_rsp_vld) begin
                if (pend_q.size() == 0) begin
                    errors++;
                    $display("response valid in cycle %0d with no transfer in flight", cyc);
                end else begin
                    p = pend_q.pop_front();
                    nm = $sformatf("%s", p.name);
                    nrsp++;
                    // fixed response delay of two cycles
                    compare(nm, "rsp cycle", p.acc_cyc + 2, cyc);
                    compare(nm, "rdt", p.rdt, man_rsp.rdt);
                    compare(nm, "err", 32'(p.err), 32'(man_rsp.err));
                    if (p.chk) begin
                        compare(nm, "table rdt", p.tab_rdt, man_rsp.rdt);
                        compare(nm, "table err", 32'(p.tab_err), 32'(man_rsp.err));
                    end
                end
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin : driver
        tcb_req_t req;
        vec_t     v;
        int       stall;
        int       acc_cyc;
        logic     prev_wen;
        void'($urandom(18));
        arst_n   = 1'b0;
        man_vld  = 1'b0;
        man_req  = '0;
        prev_wen = 1'b0;
        repeat (2) @(posedge man);
        arst_n <= 1'b1;

        // idle state straight out of reset
        @(negedge man);
        compare("reset", "rsp_vld", 32'(0), 32'(man_rsp_vld));
        compare("reset", "rdy", 32'(1), 32'(man_rdy));
        compare("reset", "rdt", 32'(0), man_rsp.rdt);
        compare("reset", "err", 32'(0), 32'(man_rsp.err));
        @(posedge man);

        for (int i = 0; i < ROWS; i++) begin
            v           = vec[i];
            req.wen     = v.wen;
            req.mod     = v.mod;
            req.sel     = v.sel;
            req.adr     = v.adr;
            req.wdt     = v.rnd ? $urandom() : v.wdt;
            man_vld <= 1'b1;
            man_req <= req;
            // count cycles with rdy low before the accept edge
            stall = 0;
            @(negedge man);
            while (!man_rdy) begin
                stall++;
                @(negedge man);
            end
            compare($sformatf("%s", v.name), "stall", 32'(prev_wen), 32'(stall));
            acc_cyc = cyc;
            @(posedge man);
            predict_response(req, v, acc_cyc);
            prev_wen = req.wen;
        end
        man_vld <= 1'b0;

        // wait for the responses still in flight
        while (pend_q.size() != 0) begin
            @(negedge man);
        end
        repeat (2) @(negedge man);

        $display("checks %0d, errors %0d, responses %0d of %0d", checks, errors, nrsp, ROWS);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+bench
hdl/tcb_pkg.sv
hdl/tcb_delay_ctrl.sv
hdl/tcb_register_response.sv
hdl/tcb_sram_sub.sv
hdl/tcb_subsystem_top.sv
bench/tcb_tb.sv

//--- Makefile
# Verilator build and run for the TCB subsystem testbench
# variables can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tcb_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(wildcard hdl/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
